// ==== design/zap_fetch_pkg.sv ====
package zap_fetch_pkg;

        // Instruction and PC width.
        localparam int WORD_W = 32;

        // Thumb flag position in the CPSR.
        localparam int CPSR_T = 5;

        // Offset of the visible PC from the fetch PC.
        localparam logic [WORD_W-1:0] PC_OFFSET_ARM   = 32'd8;  // ARM state.
        localparam logic [WORD_W-1:0] PC_OFFSET_THUMB = 32'd4;  // Thumb state.

        // Two-bit saturating branch prediction state.
        typedef enum logic [1:0]
        {
                SNT = 2'd0,     // Strongly not taken.
                WNT = 2'd1,     // Weakly not taken.
                WT  = 2'd2,     // Weakly taken.
                ST  = 2'd3      // Strongly taken.
        } bp_state_t;

endpackage

// ==== design/bp_ram.sv ====
module bp_ram
        import zap_fetch_pkg::*;
#(
        parameter int NUMBER_OF_ENTRIES = 1024  // Power of two.
)
(
        input  logic                                 i_clk,
        input  logic                                 i_reset,    // Sync, active high.

        // Write port, driven by the ALU update path.
        input  logic                                 i_wr_en,
        input  logic [$clog2(NUMBER_OF_ENTRIES)-1:0] i_wr_addr,
        input  bp_state_t                            i_wr_data,

        // Read port, indexed by the fetch PC.
        input  logic [$clog2(NUMBER_OF_ENTRIES)-1:0] i_rd_addr,
        output bp_state_t                            o_rd_data   // Valid one edge later.
);

// Table of prediction states.
bp_state_t mem [0:NUMBER_OF_ENTRIES-1];

// Registered read, single write port.
// A read and write to the same entry in one cycle returns the old state,
// since both use the pre-edge contents.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                // Whole table starts strongly not taken.
                for (int i = 0; i < NUMBER_OF_ENTRIES; i++)
                begin
                        mem[i] <= SNT;
                end
                o_rd_data <= SNT;               // First read after reset is SNT.
        end
        else
        begin
                if (i_wr_en)
                begin
                        mem[i_wr_addr] <= i_wr_data;    // Update on confirm or flush.
                end
                o_rd_data <= mem[i_rd_addr];            // Old data on collision.
        end
end

// Write enable comes from the fetch stage's update decode and must be clean.
a_wr_en_known: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !$isunknown(i_wr_en)
) else $error("bp_ram write enable is unknown");

endmodule

// ==== design/zap_fetch_main.sv ====
module zap_fetch_main
        import zap_fetch_pkg::*;
#(
        parameter int BP_ENTRIES = 1024         // Table size, power of two.
)
(
        input  logic              i_clk,
        input  logic              i_reset,                // Sync, active high.

        // Clear and stall requests, highest priority first.
        input  logic              i_clear_from_writeback,
        input  logic              i_data_stall,
        input  logic              i_clear_from_alu,
        input  logic              i_stall_from_shifter,
        input  logic              i_stall_from_issue,
        input  logic              i_stall_from_decode,
        input  logic              i_clear_from_decode,

        input  logic [WORD_W-1:0] i_pc_ff,                // Fetch PC from writeback.
        input  logic [WORD_W-1:0] i_cpsr_ff,              // Current CPSR.

        // Instruction cache side.
        input  logic [WORD_W-1:0] i_instruction,
        input  logic              i_valid,
        input  logic              i_instr_abort,

        // Decode side.
        output logic [WORD_W-1:0] o_instruction,
        output logic              o_valid,
        output logic              o_instr_abort,
        output logic [WORD_W-1:0] o_pc_plus_8_ff,         // PC + 8, or + 4 in Thumb.
        output logic [WORD_W-1:0] o_pc_ff,

        // Branch predictor update and lookup.
        input  logic              i_confirm_from_alu,
        input  logic [WORD_W-1:0] i_pc_from_alu,
        input  bp_state_t         i_taken,                // State the ALU predicted with.
        output bp_state_t         o_taken_ff              // Lookup for the fetch PC.
);

localparam int IDX_W = $clog2(BP_ENTRIES);               // Table index width.

logic              sleep_ff;    // Set by an abort, cleared by any clear.
logic              instr_stall; // Any stall request.
logic [WORD_W-1:0] pc_offset;

// Predictor port signals.
logic              bp_wr_en;
logic [IDX_W-1:0]  bp_wr_idx;
logic [IDX_W-1:0]  bp_rd_idx;
bp_state_t         bp_wr_state;

assign instr_stall = i_data_stall | i_stall_from_shifter |
                     i_stall_from_issue | i_stall_from_decode;

// Thumb instructions see PC + 4.
assign pc_offset = i_cpsr_ff[CPSR_T] ? PC_OFFSET_THUMB : PC_OFFSET_ARM;

// Decode-facing control registers with the fixed clear/stall priority.
// A stall leaves everything in place.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_valid        <= 1'b0;
                o_instr_abort  <= 1'b0;
                sleep_ff       <= 1'b0;
                o_pc_plus_8_ff <= PC_OFFSET_ARM;        // PC of zero in ARM state.
        end
        else if (i_clear_from_writeback)
        begin
                o_valid       <= 1'b0;
                o_instr_abort <= 1'b0;
                sleep_ff      <= 1'b0;                  // Wake up.
        end
        else if (i_data_stall)
        begin
                o_valid <= o_valid;                     // Hold.
        end
        else if (i_clear_from_alu)
        begin
                o_valid       <= 1'b0;
                o_instr_abort <= 1'b0;
                sleep_ff      <= 1'b0;                  // Wake up.
        end
        else if (i_stall_from_shifter | i_stall_from_issue | i_stall_from_decode)
        begin
                o_valid <= o_valid;                     // Hold.
        end
        else if (i_clear_from_decode)
        begin
                o_valid       <= 1'b0;
                o_instr_abort <= 1'b0;
                sleep_ff      <= 1'b0;
        end
        else if (sleep_ff)
        begin
                // Asleep. Nothing goes to decode.
                o_valid       <= 1'b0;
                o_instr_abort <= 1'b0;
        end
        else
        begin
                o_valid        <= i_valid;
                o_instr_abort  <= i_instr_abort;        // Travels down as a marker.
                o_pc_plus_8_ff <= i_pc_ff + pc_offset;
                if (i_instr_abort)
                begin
                        sleep_ff <= 1'b1;               // Sleep until cleared.
                end
        end
end

// Instruction word only freezes on a stall; a clear just drops o_valid.
always_ff @(posedge i_clk)
begin
        if (!instr_stall)
        begin
                o_instruction <= i_instruction;
        end
end

// PC is passed along every cycle.
always_ff @(posedge i_clk)
begin
        o_pc_ff <= i_reset ? '0 : i_pc_ff;
end

// Next prediction state from the ALU outcome.
function automatic bp_state_t next_state(input bp_state_t taken, input logic flush);
        bp_state_t res;
        res = SNT;
        if (flush)
        begin
                // Misprediction. Step toward the other direction.
                case (taken)
                        SNT:     res = WNT;
                        WNT:     res = WT;
                        WT:      res = WNT;
                        ST:      res = WT;
                        default: res = SNT;
                endcase
        end
        else
        begin
                // Confirmed. Saturate in the predicted direction.
                case (taken)
                        SNT:     res = SNT;
                        WNT:     res = SNT;
                        WT:      res = ST;
                        ST:      res = ST;
                        default: res = SNT;
                endcase
        end
        return res;
endfunction

// Updates are dropped under a data stall.
assign bp_wr_en    = !i_data_stall && (i_clear_from_alu || i_confirm_from_alu);
assign bp_wr_idx   = i_pc_from_alu[IDX_W:1];            // Halfword aligned index.
assign bp_rd_idx   = i_pc_ff[IDX_W:1];
assign bp_wr_state = next_state(i_taken, i_clear_from_alu);

bp_ram #(
        .NUMBER_OF_ENTRIES (BP_ENTRIES)
) u_br_ram (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr_en   (bp_wr_en),
        .i_wr_addr (bp_wr_idx),
        .i_wr_data (bp_wr_state),
        .i_rd_addr (bp_rd_idx),
        .o_rd_data (o_taken_ff)
);

// The cache faults only on a miss, so an abort never comes with valid data.
a_abort_not_valid: assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(i_instr_abort && i_valid)
) else $error("instruction abort raised with a valid instruction");

endmodule

// ==== design/zap_fetch_top.sv ====
module zap_fetch_top
        import zap_fetch_pkg::*;
#(
        parameter int BP_ENTRIES = 1024         // History table size.
)
(
        input  logic              i_clk,
        input  logic              i_reset,

        // Pipeline control, high priority first.
        input  logic              i_clear_from_writeback,
        input  logic              i_data_stall,
        input  logic              i_clear_from_alu,
        input  logic              i_stall_from_shifter,
        input  logic              i_stall_from_issue,
        input  logic              i_stall_from_decode,
        input  logic              i_clear_from_decode,

        input  logic [WORD_W-1:0] i_pc_ff,
        input  logic [WORD_W-1:0] i_cpsr_ff,

        // From instruction cache.
        input  logic [WORD_W-1:0] i_instruction,
        input  logic              i_valid,
        input  logic              i_instr_abort,

        // To decode.
        output logic [WORD_W-1:0] o_instruction,
        output logic              o_valid,
        output logic              o_instr_abort,
        output logic [WORD_W-1:0] o_pc_ff,
        output logic [WORD_W-1:0] o_pc_plus_8_ff,

        // Predictor.
        input  logic              i_confirm_from_alu,
        input  logic [WORD_W-1:0] i_pc_from_alu,
        input  bp_state_t         i_taken,
        output bp_state_t         o_taken_ff
);

zap_fetch_main #(
        .BP_ENTRIES (BP_ENTRIES)
) u_fetch_main (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_stall_from_decode    (i_stall_from_decode),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_ff                (i_pc_ff),
        .i_cpsr_ff              (i_cpsr_ff),
        .i_instruction          (i_instruction),
        .i_valid                (i_valid),
        .i_instr_abort          (i_instr_abort),
        .o_instruction          (o_instruction),
        .o_valid                (o_valid),
        .o_instr_abort          (o_instr_abort),
        .o_pc_plus_8_ff         (o_pc_plus_8_ff),
        .o_pc_ff                (o_pc_ff),
        .i_confirm_from_alu     (i_confirm_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_taken                (i_taken),
        .o_taken_ff             (o_taken_ff)
);

endmodule

// ==== verification/zap_fetch_tb.sv ====
module zap_fetch_tb
        import zap_fetch_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int RESET_TIMEOUT = 10;      // Cycles allowed for the DUT to leave reset.
localparam int FILE_TIMEOUT  = 2000;    // Cycles allowed for the whole file.

// PC held through reset. Sets every table index bit.
localparam logic [WORD_W-1:0] RESET_PC = 32'h0000_07fe;

logic              i_clk;
logic              i_reset;
logic              i_clear_from_writeback;
logic              i_data_stall;
logic              i_clear_from_alu;
logic              i_stall_from_shifter;
logic              i_stall_from_issue;
logic              i_stall_from_decode;
logic              i_clear_from_decode;
logic [WORD_W-1:0] i_pc_ff;
logic [WORD_W-1:0] i_cpsr_ff;
logic [WORD_W-1:0] i_instruction;
logic              i_valid;
logic              i_instr_abort;
logic              i_confirm_from_alu;
logic [WORD_W-1:0] i_pc_from_alu;
bp_state_t         i_taken;
logic [WORD_W-1:0] o_instruction;
logic              o_valid;
logic              o_instr_abort;
logic [WORD_W-1:0] o_pc_ff;
logic [WORD_W-1:0] o_pc_plus_8_ff;
bp_state_t         o_taken_ff;

int    errors;          // All mismatches.
int    test_errors;     // Mismatches in the current test.
int    tests_run;
int    tests_failed;
bit    hard_fail;       // Timeout or file problem.
string test_name;

// Pending expect fields, checked one edge after the next drive.
bit    pending;
string e_instr, e_valid, e_abort, e_pc, e_pc8, e_taken;

zap_fetch_top #(
        .BP_ENTRIES (1024)
) uut (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_stall_from_decode    (i_stall_from_decode),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_ff                (i_pc_ff),
        .i_cpsr_ff              (i_cpsr_ff),
        .i_instruction          (i_instruction),
        .i_valid                (i_valid),
        .i_instr_abort          (i_instr_abort),
        .o_instruction          (o_instruction),
        .o_valid                (o_valid),
        .o_instr_abort          (o_instr_abort),
        .o_pc_ff                (o_pc_ff),
        .o_pc_plus_8_ff         (o_pc_plus_8_ff),
        .i_confirm_from_alu     (i_confirm_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_taken                (i_taken),
        .o_taken_ff             (o_taken_ff)
);

always #5 i_clk = ~i_clk;       // 10 ns period.

task automatic check_word(input string field, input logic [WORD_W-1:0] exp,
                          input logic [WORD_W-1:0] act);
        if (act !== exp)
        begin
                $display("mismatch in test %s, %s: expected %h, actual %h",
                         test_name, field, exp, act);
                errors++;
                test_errors++;
        end
endtask

task automatic check_bit(input string field, input logic exp, input logic act);
        if (act !== exp)
        begin
                $display("mismatch in test %s, %s: expected %b, actual %b",
                         test_name, field, exp, act);
                errors++;
                test_errors++;
        end
endtask

task automatic check_state(input string field, input bp_state_t exp, input bp_state_t act);
        if (act !== exp)
        begin
                $display("mismatch in test %s, %s: expected %s, actual %s",
                         test_name, field, exp.name(), act.name());
                errors++;
                test_errors++;
        end
endtask

// Compares the stored expect line against the outputs. A dash skips a field.
task automatic compare_outputs();
        logic [WORD_W-1:0] v;
        v = '0;
        if (e_instr != "-")
        begin
                void'($sscanf(e_instr, "%h", v));
                check_word("o_instruction", v, o_instruction);
        end
        if (e_valid != "-")
        begin
                void'($sscanf(e_valid, "%h", v));
                check_bit("o_valid", v[0], o_valid);
        end
        if (e_abort != "-")
        begin
                void'($sscanf(e_abort, "%h", v));
                check_bit("o_instr_abort", v[0], o_instr_abort);
        end
        if (e_pc != "-")
        begin
                void'($sscanf(e_pc, "%h", v));
                check_word("o_pc_ff", v, o_pc_ff);
        end
        if (e_pc8 != "-")
        begin
                void'($sscanf(e_pc8, "%h", v));
                check_word("o_pc_plus_8_ff", v, o_pc_plus_8_ff);
        end
        if (e_taken != "-")
        begin
                void'($sscanf(e_taken, "%h", v));
                check_state("o_taken_ff", bp_state_t'(v[1:0]), o_taken_ff);
        end
        pending = 1'b0;
endtask

// Lets the last driven vector get captured, then checks it.
task automatic flush_pending();
        if (pending)
        begin
                @(posedge i_clk);
                @(negedge i_clk);
                compare_outputs();
        end
endtask

task automatic report_test();
        if (tests_run > 0)
        begin
                if (test_errors == 0)
                        $display("test %s: ok", test_name);
                else
                begin
                        $display("test %s: %0d mismatches", test_name, test_errors);
                        tests_failed++;
                end
        end
endtask

initial
begin
        int    fd;
        int    cycles;
        int    n;
        string line;
        string kw;
        logic [WORD_W-1:0] f [0:14];

        i_clk = 1'b0;
        i_reset = 1'b1;
        i_clear_from_writeback = 1'b0;
        i_data_stall = 1'b0;
        i_clear_from_alu = 1'b0;
        i_stall_from_shifter = 1'b0;
        i_stall_from_issue = 1'b0;
        i_stall_from_decode = 1'b0;
        i_clear_from_decode = 1'b0;
        i_pc_ff = RESET_PC;             // Nonzero so reset of o_pc_ff shows.
        i_cpsr_ff = '0;
        i_instruction = '0;
        i_valid = 1'b0;
        i_instr_abort = 1'b0;
        i_confirm_from_alu = 1'b0;
        i_pc_from_alu = '0;
        i_taken = SNT;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        hard_fail = 1'b0;
        pending = 1'b0;
        test_name = "power_on";
        tests_run++;

        // Offsets in the package must match the architecture.
        check_word("PC_OFFSET_ARM", 32'd8, PC_OFFSET_ARM);
        check_word("PC_OFFSET_THUMB", 32'd4, PC_OFFSET_THUMB);

        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;

        // Reset state, still in place until the next edge.
        @(negedge i_clk);
        check_bit("o_valid", 1'b0, o_valid);
        check_bit("o_instr_abort", 1'b0, o_instr_abort);
        check_word("o_pc_plus_8_ff", 32'd8, o_pc_plus_8_ff);
        check_word("o_pc_ff", 32'd0, o_pc_ff);
        check_state("o_taken_ff", SNT, o_taken_ff);

        cycles = 0;
        while (o_pc_ff !== RESET_PC && cycles < RESET_TIMEOUT)  // First capture.
        begin
                @(negedge i_clk);
                cycles++;
        end
        if (o_pc_ff !== RESET_PC)
        begin
                $display("the DUT did not leave reset in time");
                hard_fail = 1'b1;
        end
        else
        begin
                check_state("o_taken_ff", SNT, o_taken_ff);     // Far table entry reset too.
        end

        fd = 0;
        if (!hard_fail)
        begin
                fd = $fopen("verification/fetch_golden.txt", "r");
                if (fd == 0)
                begin
                        $display("could not open the golden file");
                        hard_fail = 1'b1;
                end
        end

        cycles = 0;
        while (!hard_fail && !$feof(fd))
        begin
                if (cycles > FILE_TIMEOUT)
                begin
                        $display("golden file did not end within %0d cycles", FILE_TIMEOUT);
                        hard_fail = 1'b1;
                end
                else if ($fgets(line, fd) != 0 && $sscanf(line, "%s", kw) == 1
                         && line.getc(0) != "#")
                begin
                        if (kw == "test")
                        begin
                                flush_pending();
                                report_test();
                                void'($sscanf(line, "%s %s", kw, test_name));
                                test_errors = 0;
                                tests_run++;
                        end
                        else if (kw == "drive")
                        begin
                                n = $sscanf(line,
                                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                        kw, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                                if (n != 16)
                                begin
                                        $display("drive line has the wrong field count");
                                        hard_fail = 1'b1;
                                end
                                @(posedge i_clk);
                                i_clear_from_writeback <= f[0][0];
                                i_data_stall           <= f[1][0];
                                i_clear_from_alu       <= f[2][0];
                                i_stall_from_shifter   <= f[3][0];
                                i_stall_from_issue     <= f[4][0];
                                i_stall_from_decode    <= f[5][0];
                                i_clear_from_decode    <= f[6][0];
                                i_pc_ff                <= f[7];
                                i_cpsr_ff              <= f[8];
                                i_instruction          <= f[9];
                                i_valid                <= f[10][0];
                                i_instr_abort          <= f[11][0];
                                i_confirm_from_alu     <= f[12][0];
                                i_pc_from_alu          <= f[13];
                                i_taken                <= bp_state_t'(f[14][1:0]);
                                cycles++;
                                if (pending)
                                begin
                                        @(negedge i_clk);   // Previous vector now captured.
                                        compare_outputs();
                                end
                        end
                        else if (kw == "expect")
                        begin
                                n = $sscanf(line, "%s %s %s %s %s %s %s", kw, e_instr,
                                            e_valid, e_abort, e_pc, e_pc8, e_taken);
                                if (n != 7)
                                begin
                                        $display("expect line has the wrong field count");
                                        hard_fail = 1'b1;
                                end
                                pending = 1'b1;
                        end
                end
        end
        if (!hard_fail)
        begin
                flush_pending();
                report_test();
        end

        $display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !hard_fail && tests_run > 0)
                $display("Testbench passed");
        else
                $display("Testbench failed");
        $finish;
end

endmodule

// ==== verification/fetch_golden.txt ====
# drive: wb dstall aluclr shstall isstall dcstall dcclr pc cpsr instr valid abort confirm pcalu taken
# expect: instr valid abort pc pc_plus_8 taken (dash = not checked)
test reset
drive 0 0 0 0 0 0 0 00000000 00000000 00000000 0 0 0 00000000 0
expect - 0 0 00000000 00000008 0
drive 0 0 0 0 0 0 0 00000000 00000000 00000000 0 0 0 00000000 0
test forward
drive 0 0 0 0 0 0 0 00001000 00000000 e3a01001 1 0 0 00000000 0
expect e3a01001 1 0 00001000 00001008 0
drive 0 0 0 0 0 0 0 00001004 00000020 00004770 1 0 0 00000000 0
expect 00004770 1 0 00001004 00001008 0
drive 0 0 0 0 0 0 0 00000000 00000000 00000000 0 0 0 00000000 0
test stall_priority
drive 0 0 0 0 0 0 0 00002000 00000000 aaaa0001 1 0 0 00000000 0
expect aaaa0001 1 0 00002000 00002008 0
drive 0 1 0 0 0 0 0 00002004 00000000 bbbb0002 0 0 0 00000000 0
expect aaaa0001 1 0 00002004 00002008 0
drive 1 1 0 0 0 0 0 00002008 00000000 cccc0003 1 0 0 00000000 0
expect aaaa0001 0 0 00002008 00002008 0
drive 0 0 0 0 0 0 0 0000200c 00000000 dddd0004 1 0 0 00000000 0
expect dddd0004 1 0 0000200c 00002014 0
drive 0 1 1 0 0 0 0 00002010 00000000 eeee0005 1 0 0 00000000 0
expect dddd0004 1 0 00002010 00002014 0
drive 0 0 0 0 0 1 1 00002014 00000000 ffff0006 1 0 0 00000000 0
expect dddd0004 1 0 00002014 00002014 0
drive 0 0 0 0 0 0 1 00002018 00000000 12340007 1 0 0 00000000 0
expect 12340007 0 0 00002018 00002014 0
drive 0 0 0 0 0 0 0 00000000 00000000 00000000 0 0 0 00000000 0
test abort_sleep
drive 0 0 0 0 0 0 0 00003000 00000000 00000000 0 1 0 00000000 0
expect - 0 1 00003000 00003008 0
drive 0 0 0 0 0 0 0 00003004 00000000 11110001 1 0 0 00000000 0
expect 11110001 0 0 00003004 00003008 0
drive 0 0 0 0 0 0 0 00003008 00000000 22220002 1 0 0 00000000 0
expect 22220002 0 0 00003008 00003008 0
drive 1 0 0 0 0 0 0 0000300c 00000000 33330003 1 0 0 00000000 0
expect 33330003 0 0 0000300c 00003008 0
drive 0 0 0 0 0 0 0 00003010 00000000 44440004 1 0 0 00000000 0
expect 44440004 1 0 00003010 00003018 0
drive 0 0 0 0 0 0 0 00000000 00000000 00000000 0 0 0 00000000 0
test predictor
drive 0 0 0 0 0 0 0 00000000 00000000 00000000 0 0 1 00004010 2
expect - 0 0 00000000 00000008 0
drive 0 0 0 0 0 0 0 00000010 00000000 00000000 0 0 0 00000000 0
expect - 0 0 00000010 00000018 3
drive 0 0 1 0 0 0 0 00000010 00000000 00000000 0 0 0 00004010 3
expect - 0 0 00000010 00000018 3
drive 0 0 0 0 0 0 0 00000010 00000000 00000000 0 0 0 00000000 0
expect - 0 0 00000010 00000018 2
drive 0 1 0 0 0 0 0 00000010 00000000 00000000 0 0 1 00004010 0
expect - 0 0 00000010 00000018 2
drive 0 0 0 0 0 0 0 00000010 00000000 00000000 0 0 0 00000000 0
expect - 0 0 00000010 00000018 2
drive 0 0 1 0 0 0 0 00000010 00000000 00000000 0 0 0 00004010 0
expect - 0 0 00000010 00000018 2
drive 0 0 0 0 0 0 0 00000010 00000000 00000000 0 0 0 00000000 0
expect - 0 0 00000010 00000018 1
drive 0 0 0 0 0 0 0 00000010 00000000 00000000 0 0 1 00004010 1
expect - 0 0 00000010 00000018 1
drive 0 0 0 0 0 0 0 00000010 00000000 00000000 0 0 0 00000000 0
expect - 0 0 00000010 00000018 0

// ==== flist.f ====
design/zap_fetch_pkg.sv
design/bp_ram.sv
design/zap_fetch_main.sv
design/zap_fetch_top.sv
verification/zap_fetch_tb.sv

// ==== Makefile ====
TOP := zap_fetch_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module zap_fetch_top
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
